// ==== vlog.f ====
verilog/xt_bus_pkg.sv
verilog/xt_map_pkg.sv
verilog/xt_bus_decoder.sv
verilog/ems_mapper.sv
verilog/system_port_regs.sv
verilog/sram_address_mux.sv
verilog/chipset_read_mux.sv
verilog/xt_chipset_top.sv
tests/tb_xt_chipset.sv

// ==== run.sh ====
#!/bin/bash
# build and run the chipset testbench with verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_xt_chipset \
		-f vlog.f -o tb_xt_chipset &&
	./obj_dir/tb_xt_chipset | tee /dev/stderr | grep -q "Finished with no errors" &&
	echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }

// ==== tests/tb_xt_chipset.sv ====
`timescale 1ns/100ps

module tb_xt_chipset;
	import xt_bus_pkg::*;
	import xt_map_pkg::*;

	localparam int valid_timeout = 8;

	// {aen_n, io_read_n, io_write_n, mem_read_n, mem_write_n}
	localparam logic [4:0] idle_cycle = 5'b01111;
	localparam logic [4:0] io_rd = 5'b00111;
	localparam logic [4:0] io_wr = 5'b01011;
	localparam logic [4:0] mem_rd = 5'b01101;
	localparam logic [4:0] mem_wr = 5'b01110;
	localparam logic [4:0] dma_io_rd = 5'b10111;
	localparam logic [4:0] dma_mem_wr = 5'b11110;

	// aliases of the low block and ports that must stay unselected
	localparam logic [15:0] upper_ports [6] = '{16'h0100, 16'h0260, 16'h0378,
		16'h03DF, 16'h0440, 16'h1040};

	logic clock;
	logic reset;
	cpu_bus_t bus_i;
	logic ems_enable_i;
	logic [1:0] ems_frame_i;
	logic tandy_mode_i;
	logic tandy_gfx_i;
	logic [7:0] sram_data_i;
	sram_addr_t sram_addr_o;
	logic sram_we_n_o;
	logic [7:0] io_select_n_o;
	logic [7:0] data_o;
	logic data_valid_o;
	int errors;

	xt_chipset_top i_dut (.*);

	always #50 clock = ~clock;

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic bus_idle();
		bus_i.addr = '0;
		bus_i.data = 8'h00;
		{bus_i.aen_n, bus_i.io_read_n, bus_i.io_write_n, bus_i.mem_read_n,
			bus_i.mem_write_n} = idle_cycle;
	endtask

	// returns mid-cycle with the strobes settled
	task automatic start_cycle(input logic [19:0] addr, input logic [7:0] value,
		input logic [4:0] cycle);
		@(posedge clock);
		#10;
		bus_i.addr = addr;
		bus_i.data = value;
		{bus_i.aen_n, bus_i.io_read_n, bus_i.io_write_n, bus_i.mem_read_n,
			bus_i.mem_write_n} = cycle;
		#10;
	endtask

	task automatic end_cycle();
		@(posedge clock);
		#10;
		bus_idle();
	endtask

	task automatic io_write(input logic [19:0] port, input logic [7:0] value);
		start_cycle(port, value, io_wr);
		end_cycle();
	endtask

	task automatic read_cycle(input string name, input logic [19:0] addr,
		input logic [4:0] cycle, input logic expect_valid, input logic [7:0] expected);
		logic seen;
		int i;
		start_cycle(addr, 8'h00, cycle);
		seen = 1'b0;
		for (i = 0; i < valid_timeout && !seen; i++) begin
			@(posedge clock);
			#10;
			seen = data_valid_o;
		end
		if (!expect_valid) begin
			check(name, 32'h0, 32'(seen));
		end else if (!seen) begin
			errors++;
			$display("%s: no data_valid_o within %0d cycles", name, valid_timeout);
		end else begin
			check(name, 32'(expected), 32'(data_o));
		end
		bus_idle();
	endtask

	// low block decode looks at port bits 9:5 only
	function automatic logic [7:0] expected_select(input logic [15:0] port);
		logic [7:0] sel;
		int n;
		sel = 8'hFF;
		if (port[9:8] == 2'b00) begin
			for (n = 0; n < 8; n++) begin
				if (port[7:5] == 3'(n))
					sel[n] = 1'b0;
			end
		end
		return sel;
	endfunction

	task automatic port_register_access();
		logic [7:0] v;
		logic [19:0] nmi_port;
		read_cycle("lpt_reset", 20'h00378, io_rd, 1'b1, 8'hFF);
		read_cycle("page_reset", 20'h003DF, io_rd, 1'b1, 8'h00);
		read_cycle("nmi_reset", 20'h000A0, io_rd, 1'b1, 8'hFF);
		v = 8'($urandom);
		io_write(20'h00378, v);
		read_cycle("lpt_write", 20'h00378, io_rd, 1'b1, v);
		v = 8'($urandom);
		io_write(20'h003DF, v);
		read_cycle("page_write", 20'h003DF, io_rd, 1'b1, v);
		v = 8'($urandom);
		nmi_port = 20'h000A0 + 20'($urandom % 8);
		io_write(nmi_port, v);
		read_cycle("nmi_write", nmi_port, io_rd, 1'b1, v);
		tandy_mode_i = 1'b0;
		read_cycle("nmi_hidden", nmi_port, io_rd, 1'b0, 8'h00);
		tandy_mode_i = 1'b1;
	endtask

	task automatic io_select_sweep();
		int i;
		logic [15:0] port;
		for (i = 0; i < 256 + 6; i++) begin
			port = (i < 256) ? 16'(i) : upper_ports[i - 256];
			start_cycle({4'h0, port}, 8'h00, io_rd);
			check("io_decode", 32'(expected_select(port)), 32'(io_select_n_o));
			end_cycle();
		end
		start_cycle(20'h00040, 8'h00, mem_rd);
		check("io_decode_mem", 32'hFF, 32'(io_select_n_o));
		end_cycle();
		start_cycle(20'h00040, 8'h00, dma_io_rd);
		check("io_decode_dma", 32'hFF, 32'(io_select_n_o));
		end_cycle();
	endtask

	task automatic ems_register_rules();
		int i;
		logic [19:0] port;
		logic [6:0] pg;
		for (i = 0; i < 4; i++) begin
			port = 20'h00260 + 20'(i);
			read_cycle("ems_reset", port, io_rd, 1'b1, 8'hFF);
			pg = 7'($urandom);
			// page must differ from the low bits of 0x90
			if (pg[5:0] == 6'h10)
				pg[5:0] = 6'h11;
			io_write(port, {1'b0, pg});
			read_cycle("ems_set", port, io_rd, 1'b1, {2'b00, pg[5:0]});
			// codes from 0x80 up to 0xFE are ignored
			io_write(port, 8'h90);
			read_cycle("ems_ignore", port, io_rd, 1'b1, {2'b00, pg[5:0]});
			io_write(port, 8'hFF);
			read_cycle("ems_clear", port, io_rd, 1'b1, 8'hFF);
		end
		ems_enable_i = 1'b0;
		read_cycle("ems_hidden", 20'h00261, io_rd, 1'b0, 8'h00);
		ems_enable_i = 1'b1;
	endtask

	task automatic ems_frame_mapping();
		int f;
		int s;
		logic [5:0] pages [4];
		logic [3:0] seg;
		logic [19:0] a;
		sram_addr_t expected;
		for (s = 0; s < 4; s++) begin
			pages[s] = 6'($urandom);
			io_write(20'h00260 + 20'(s), {2'b00, pages[s]});
		end
		// page 3 stays disabled
		io_write(20'h00263, 8'hFF);
		for (f = 0; f < 4; f++) begin
			ems_frame_i = 2'(f);
			seg = (f == 0) ? 4'hC : (f == 1) ? 4'hD : 4'hE;
			for (s = 0; s < 5; s++) begin
				a = {seg, 2'(s), 14'($urandom)};
				// fifth access lies outside the frame
				if (s == 4)
					a[19:16] = 4'hA;
				if (s < 3)
					expected = {1'b1, pages[s], a[13:0]};
				else
					expected = {1'b0, a};
				start_cycle(a, 8'h00, mem_rd);
				check("ems_map", 32'(expected), 32'(sram_addr_o));
				end_cycle();
			end
		end
	endtask

	task automatic tandy_paging();
		int k;
		logic [7:0] nmi_v;
		logic [7:0] page_v;
		logic [19:0] a;
		sram_addr_t expected;
		ems_enable_i = 1'b0;
		for (k = 0; k < 4; k++) begin
			nmi_v = 8'($urandom);
			page_v = 8'($urandom);
			page_v[3] = k[1];
			io_write(20'h000A0, nmi_v);
			io_write(20'h003DF, page_v);
			a = {5'b10111, k[0], 14'($urandom)};
			expected = {1'b0, nmi_v[3:1], page_v[5:4], page_v[3] | a[14], a[13:0]};
			tandy_gfx_i = 1'b1;
			start_cycle(a, 8'h00, mem_rd);
			check("tandy_map", 32'(expected), 32'(sram_addr_o));
			end_cycle();
			tandy_gfx_i = 1'b0;
			start_cycle(a, 8'h00, mem_rd);
			check("tandy_off", 32'({1'b0, a}), 32'(sram_addr_o));
			end_cycle();
		end
	endtask

	task automatic memory_cycles();
		int i;
		sram_data_i = 8'($urandom);
		read_cycle("mem_read", 20'h12345, mem_rd, 1'b1, sram_data_i);
		start_cycle(20'h12345, 8'h5A, mem_wr);
		check("we_mem_write", 32'h0, 32'(sram_we_n_o));
		end_cycle();
		start_cycle(20'h12345, 8'h5A, dma_mem_wr);
		check("we_dma", 32'h1, 32'(sram_we_n_o));
		end_cycle();
		start_cycle(20'h12345, 8'h00, mem_rd);
		check("we_mem_read", 32'h1, 32'(sram_we_n_o));
		end_cycle();
		start_cycle(20'h002F8, 8'h5A, io_wr);
		check("we_io_write", 32'h1, 32'(sram_we_n_o));
		end_cycle();
		for (i = 0; i < 3; i++) begin
			@(posedge clock);
			#10;
			check("idle_valid", 32'h0, 32'(data_valid_o));
		end
	endtask

	initial begin
		errors = 0;
		void'($urandom(25));
		clock = 1'b0;
		reset = 1'b1;
		bus_idle();
		ems_enable_i = 1'b0;
		ems_frame_i = 2'b00;
		tandy_mode_i = 1'b1;
		tandy_gfx_i = 1'b0;
		sram_data_i = 8'h00;
		repeat (5) @(posedge clock);
		#10;
		reset = 1'b0;
		check("reset_valid", 32'h0, 32'(data_valid_o));
		port_register_access();
		io_select_sweep();
		ems_enable_i = 1'b1;
		ems_register_rules();
		ems_frame_mapping();
		tandy_paging();
		memory_cycles();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== verilog/xt_chipset_top.sv ====
`timescale 1ns/100ps

module xt_chipset_top (
	input logic clock,
	input logic reset,
	input xt_bus_pkg::cpu_bus_t bus_i,
	input logic ems_enable_i,
	input logic [1:0] ems_frame_i,
	input logic tandy_mode_i,
	input logic tandy_gfx_i,
	input logic [7:0] sram_data_i,
	output xt_map_pkg::sram_addr_t sram_addr_o,
	output logic sram_we_n_o,
	output logic [7:0] io_select_n_o,
	output logic [7:0] data_o,
	output logic data_valid_o
);
	import xt_bus_pkg::*;
	import xt_map_pkg::*;

	reg_write_t wr;
	rd_src_t rd_src;
	logic ems_hit;
	sram_addr_t ems_addr;
	logic [7:0] ems_rb;
	logic [7:0] lpt;
	logic [7:0] page;
	logic [7:0] nmi;

	xt_bus_decoder i_decoder (
		.bus_i(bus_i),
		.ems_enable_i(ems_enable_i),
		.tandy_mode_i(tandy_mode_i),
		.io_select_n_o(io_select_n_o),
		.sram_we_n_o(sram_we_n_o),
		.wr_o(wr),
		.rd_src_o(rd_src)
	);

	ems_mapper i_ems (
		.clock(clock),
		.reset(reset),
		.bus_i(bus_i),
		.ems_wr_i(wr.ems_wr),
		.ems_frame_i(ems_frame_i),
		.hit_o(ems_hit),
		.mapped_addr_o(ems_addr),
		.readback_o(ems_rb)
	);

	system_port_regs i_ports (
		.clock(clock),
		.reset(reset),
		.data_i(bus_i.data),
		.wr_i(wr),
		.lpt_o(lpt),
		.page_o(page),
		.nmi_o(nmi)
	);

	sram_address_mux i_addr_mux (
		.bus_i(bus_i),
		.tandy_gfx_i(tandy_gfx_i),
		.ems_hit_i(ems_hit),
		.ems_addr_i(ems_addr),
		.page_i(page),
		.nmi_i(nmi),
		.sram_addr_o(sram_addr_o)
	);

	chipset_read_mux i_read_mux (
		.clock(clock),
		.reset(reset),
		.rd_src_i(rd_src),
		.lpt_i(lpt),
		.page_i(page),
		.nmi_i(nmi),
		.ems_i(ems_rb),
		.sram_data_i(sram_data_i),
		.data_o(data_o),
		.data_valid_o(data_valid_o)
	);

endmodule

// ==== verilog/chipset_read_mux.sv ====
`timescale 1ns/100ps

module chipset_read_mux (
	input logic clock,
	input logic reset,
	input xt_bus_pkg::rd_src_t rd_src_i,
	input logic [7:0] lpt_i,
	input logic [7:0] page_i,
	input logic [7:0] nmi_i,
	input logic [7:0] ems_i,
	input logic [7:0] sram_data_i,
	output logic [7:0] data_o,
	output logic data_valid_o
);
	import xt_bus_pkg::*;

	logic [7:0] next_data;
	logic next_valid;

	always_comb begin
		next_valid = 1'b1;
		case (rd_src_i)
			rd_lpt:
				next_data = lpt_i;
			rd_page:
				next_data = page_i;
			rd_nmi:
				next_data = nmi_i;
			rd_ems:
				next_data = ems_i;
			rd_sram:
				next_data = sram_data_i;
			default: begin
				next_data = 8'h00;
				next_valid = 1'b0;
			end
		endcase
	end

	// one cycle behind the decoded source
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_o <= 8'h00;
			data_valid_o <= 1'b0;
		end else begin
			data_o <= next_data;
			data_valid_o <= next_valid;
		end
	end

endmodule

// ==== verilog/sram_address_mux.sv ====
`timescale 1ns/100ps

module sram_address_mux (
	input xt_bus_pkg::cpu_bus_t bus_i,
	input logic tandy_gfx_i,
	input logic ems_hit_i,
	input xt_map_pkg::sram_addr_t ems_addr_i,
	input logic [7:0] page_i,
	input logic [7:0] nmi_i,
	output xt_map_pkg::sram_addr_t sram_addr_o
);
	import xt_map_pkg::*;

	logic in_cga;
	logic bank_lsb;
	sram_addr_t tandy_addr;

	// slot bits 5:1 are address bits 19:15
	assign in_cga = bus_i.addr.mem.slot[5:1] == cga_window;

	// page bit 3 forces the upper 16 KB half
	assign bank_lsb = page_i[3] ? 1'b1 : bus_i.addr.mem.slot[0];

	assign tandy_addr = {1'b0, nmi_i[3:1], page_i[5:4], bank_lsb, bus_i.addr.mem.offset};

	always_comb begin
		if (ems_hit_i)
			sram_addr_o = ems_addr_i;
		else if (tandy_gfx_i && in_cga)
			sram_addr_o = tandy_addr;
		else
			sram_addr_o = {1'b0, bus_i.addr};
	end

endmodule

// ==== verilog/system_port_regs.sv ====
`timescale 1ns/100ps

module system_port_regs (
	input logic clock,
	input logic reset,
	input logic [7:0] data_i,
	input xt_bus_pkg::reg_write_t wr_i,
	output logic [7:0] lpt_o,
	output logic [7:0] page_o,
	output logic [7:0] nmi_o
);
	import xt_map_pkg::*;

	// parallel port data latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			lpt_o <= lpt_reset_val;
		else if (wr_i.lpt_wr)
			lpt_o <= data_i;
	end

	// tandy video page, cpu bank in bits 5:3
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			page_o <= page_reset_val;
		else if (wr_i.page_wr)
			page_o <= data_i;
	end

	// nmi mask, bits 3:1 also give the 128 KB bank
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			nmi_o <= nmi_reset_val;
		else if (wr_i.nmi_wr)
			nmi_o <= data_i;
	end

endmodule

// ==== verilog/ems_mapper.sv ====
`timescale 1ns/100ps

module ems_mapper (
	input logic clock,
	input logic reset,
	input xt_bus_pkg::cpu_bus_t bus_i,
	input logic ems_wr_i,
	input logic [1:0] ems_frame_i,
	output logic hit_o,
	output xt_map_pkg::sram_addr_t mapped_addr_o,
	output logic [7:0] readback_o
);
	import xt_map_pkg::*;

	ems_page_t page_q [ems_pages];
	logic [ems_pages-1:0] ena_q;

	// first stage, decoded write
	logic cmd_valid_q;
	logic cmd_set_q;
	logic cmd_clear_q;
	logic [1:0] cmd_idx_q;
	ems_page_t cmd_page_q;

	logic [1:0] rd_idx;
	logic [1:0] map_idx;
	logic mem_cycle;
	logic in_frame;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			cmd_valid_q <= 1'b0;
			cmd_set_q <= 1'b0;
			cmd_clear_q <= 1'b0;
		end else begin
			cmd_valid_q <= ems_wr_i;
			cmd_set_q <= bus_i.data < ems_page_limit;
			cmd_clear_q <= bus_i.data == ems_disable_code;
		end
	end

	always_ff @(posedge clock) begin
		cmd_idx_q <= bus_i.addr.io.port[1:0];
		cmd_page_q <= bus_i.data[ems_page_w-1:0];
	end

	// second stage, commit to the page table
	// codes between 0x80 and 0xFE fall through
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ena_q <= '0;
		end else if (cmd_valid_q) begin
			if (cmd_clear_q)
				ena_q[cmd_idx_q] <= 1'b0;
			else if (cmd_set_q)
				ena_q[cmd_idx_q] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (cmd_valid_q && cmd_set_q)
			page_q[cmd_idx_q] <= cmd_page_q;
	end

	assign rd_idx = bus_i.addr.io.port[1:0];
	assign readback_o = ena_q[rd_idx] ? {2'b00, page_q[rd_idx]} : ems_disable_code;

	// frame is four 16 KB windows, slot bits 1:0 pick the page
	assign map_idx = bus_i.addr.mem.slot[1:0];
	assign mem_cycle = ~bus_i.mem_read_n | ~bus_i.mem_write_n;
	assign in_frame = bus_i.addr.mem.slot[5:2] == ems_frame_seg[ems_frame_i];
	assign hit_o = mem_cycle & in_frame & ena_q[map_idx];
	assign mapped_addr_o = {1'b1, page_q[map_idx], bus_i.addr.mem.offset};

endmodule

// ==== verilog/xt_bus_decoder.sv ====
`timescale 1ns/100ps

module xt_bus_decoder (
	input xt_bus_pkg::cpu_bus_t bus_i,
	input logic ems_enable_i,
	input logic tandy_mode_i,
	output logic [7:0] io_select_n_o,
	output logic sram_we_n_o,
	output xt_bus_pkg::reg_write_t wr_o,
	output xt_bus_pkg::rd_src_t rd_src_o
);
	import xt_bus_pkg::*;
	import xt_map_pkg::*;

	logic [15:0] port;
	logic iorq;
	logic io_rd;
	logic io_wr;
	logic mem_rd;
	logic lpt_hit;
	logic page_hit;
	logic nmi_hit;
	logic ems_hit;

	assign port = bus_i.addr.io.port;
	assign iorq = ~bus_i.aen_n & (~bus_i.io_read_n | ~bus_i.io_write_n);
	assign io_rd = ~bus_i.aen_n & ~bus_i.io_read_n;
	assign io_wr = ~bus_i.aen_n & ~bus_i.io_write_n;
	assign mem_rd = ~bus_i.aen_n & ~bus_i.mem_read_n;

	// 8 blocks of 32 ports below 0x100
	always_comb begin
		io_select_n_o = 8'hFF;
		if (iorq && (port[9:0] < sys_io_limit))
			io_select_n_o = ~(8'h01 << port[7:5]);
	end

	assign lpt_hit = port == lpt_port;
	assign page_hit = port == tandy_page_port;
	assign nmi_hit = tandy_mode_i && (port >= nmi_mask_base) &&
		(port < nmi_mask_base + 16'(nmi_mask_ports));
	assign ems_hit = ems_enable_i && (port >= ems_port_base) &&
		(port < ems_port_base + 16'(ems_pages));

	assign wr_o.lpt_wr = io_wr & lpt_hit;
	assign wr_o.page_wr = io_wr & page_hit;
	assign wr_o.nmi_wr = io_wr & nmi_hit;
	assign wr_o.ems_wr = io_wr & ems_hit;

	always_comb begin
		rd_src_o = rd_none;
		if (io_rd) begin
			if (lpt_hit)
				rd_src_o = rd_lpt;
			else if (page_hit)
				rd_src_o = rd_page;
			else if (nmi_hit)
				rd_src_o = rd_nmi;
			else if (ems_hit)
				rd_src_o = rd_ems;
		end else if (mem_rd) begin
			rd_src_o = rd_sram;
		end
	end

	assign sram_we_n_o = ~(~bus_i.aen_n & ~bus_i.mem_write_n);

endmodule

// ==== verilog/xt_map_pkg.sv ====
package xt_map_pkg;

	localparam int sram_addr_w = 21;
	localparam int ems_page_w = 6;
	localparam int ems_pages = 4;

	typedef logic [sram_addr_w-1:0] sram_addr_t;
	typedef logic [ems_page_w-1:0] ems_page_t;

	// i/o map
	localparam logic [15:0] lpt_port = 16'h0378;
	localparam logic [15:0] tandy_page_port = 16'h03DF;
	localparam logic [15:0] nmi_mask_base = 16'h00A0;
	localparam int nmi_mask_ports = 8;
	localparam logic [15:0] ems_port_base = 16'h0260;

	// only ten address lines decoded on the system board
	localparam logic [9:0] sys_io_limit = 10'h100;

	// ems frame segment per frame select, select 3 aliases 0xE
	localparam logic [3:0][3:0] ems_frame_seg = {4'hE, 4'hE, 4'hD, 4'hC};

	// 0xB8000, address bits 19:15
	localparam logic [4:0] cga_window = 5'b10111;

	// ems page register write codes
	localparam logic [7:0] ems_disable_code = 8'hFF;
	localparam logic [7:0] ems_page_limit = 8'h80;

	// register values after reset
	localparam logic [7:0] lpt_reset_val = 8'hFF;
	localparam logic [7:0] page_reset_val = 8'h00;
	localparam logic [7:0] nmi_reset_val = 8'hFF;

endpackage

// ==== verilog/xt_bus_pkg.sv ====
package xt_bus_pkg;

	// port view of the cpu address
	typedef struct packed {
		logic [3:0]  rsvd;
		logic [15:0] port;
	} io_addr_t;

	// memory view, 16 KB slots
	typedef struct packed {
		logic [5:0]  slot;
		logic [13:0] offset;
	} mem_addr_t;

	typedef union packed {
		io_addr_t  io;
		mem_addr_t mem;
	} cpu_addr_u;

	typedef struct packed {
		cpu_addr_u  addr;
		logic [7:0] data;
		logic       io_read_n;
		logic       io_write_n;
		logic       mem_read_n;
		logic       mem_write_n;
		logic       aen_n;
	} cpu_bus_t;

	typedef struct packed {
		logic lpt_wr;
		logic page_wr;
		logic nmi_wr;
		logic ems_wr;
	} reg_write_t;

	typedef enum logic [2:0] {
		rd_none,
		rd_lpt,
		rd_page,
		rd_nmi,
		rd_ems,
		rd_sram
	} rd_src_t;

endpackage
